// File: Makefile
VERILATOR ?= verilator
TOP       ?= fft16_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
hw/fft16_pkg.sv
hw/fft16_loader.sv
hw/r4_butterfly.sv
hw/fft16_twiddle.sv
hw/fft16_unloader.sv
hw/fft16_top.sv
test/fft16_asserts.sv
test/fft16_tb.sv

// File: hw/fft16_loader.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_loader (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                in_valid_i,
  input  logic signed [fft16_pkg::IN_W-1:0]   in_re_i,
  input  logic signed [fft16_pkg::IN_W-1:0]   in_im_i,
  output logic                                in_ready_o,
  input  logic                                frame_done_i,
  output logic                                frame_valid_o,
  output fft16_pkg::in_cplx_t                 frame_o [fft16_pkg::N_POINTS]
);

  fft16_pkg::in_cplx_t frame_q [fft16_pkg::N_POINTS];
  logic [3:0]          wr_cnt;
  logic                full;
  logic                credit;
  logic                accept;
  logic                launch;

  assign in_ready_o = ~full;
  assign accept     = in_valid_i & ~full;

  // A full frame leaves as soon as the pipeline is free
  assign launch        = full & credit;
  assign frame_valid_o = launch;
  assign frame_o       = frame_q;

  // Sample storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      frame_q[wr_cnt] <= {in_re_i, in_im_i};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fill and credit control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_cnt <= '0;
      full   <= 1'b0;
      credit <= 1'b1;
    end else begin
      if (accept) begin
        wr_cnt <= wr_cnt + 4'd1;
        if (wr_cnt == 4'd15) begin
          full <= 1'b1;
        end
      end
      if (launch) begin
        full <= 1'b0;
      end
      // Only one frame in flight
      if (launch) begin
        credit <= 1'b0;
      end else if (frame_done_i) begin
        credit <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fft16_pkg.sv
`default_nettype none

package fft16_pkg;

  //////////////////////////////////////////////////////////////////////
  // Frame geometry and data widths
  //////////////////////////////////////////////////////////////////////
  localparam int N_POINTS = 16;
  localparam int RADIX    = 4;

  localparam int IN_W    = 16;
  // Two bits of growth per butterfly rank
  localparam int MID_W   = 18;
  localparam int OUT_W   = 20;
  localparam int TW_FRAC = 14;

  typedef struct packed {
    logic signed [IN_W-1:0] re;
    logic signed [IN_W-1:0] im;
  } in_cplx_t;

  typedef struct packed {
    logic signed [MID_W-1:0] re;
    logic signed [MID_W-1:0] im;
  } mid_cplx_t;

  typedef struct packed {
    logic signed [OUT_W-1:0] re;
    logic signed [OUT_W-1:0] im;
  } out_cplx_t;

  //////////////////////////////////////////////////////////////////////
  // Twiddles W16^m in Q2.14
  //////////////////////////////////////////////////////////////////////
  localparam logic signed [15:0] TW_RE [N_POINTS] = '{
    16'sd16384,  16'sd15137,  16'sd11585,  16'sd6270,
    16'sd0,     -16'sd6270,  -16'sd11585, -16'sd15137,
   -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270,
    16'sd0,      16'sd6270,   16'sd11585,  16'sd15137
  };

  // Imaginary part is -sin
  localparam logic signed [15:0] TW_IM [N_POINTS] = '{
    16'sd0,     -16'sd6270,  -16'sd11585, -16'sd15137,
   -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270,
    16'sd0,      16'sd6270,   16'sd11585,  16'sd15137,
    16'sd16384,  16'sd15137,  16'sd11585,  16'sd6270
  };

endpackage

`default_nettype wire

// File: hw/fft16_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_top #(
  parameter int DATA_IN_W  = fft16_pkg::IN_W,
  parameter int DATA_OUT_W = fft16_pkg::OUT_W
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic signed [DATA_IN_W-1:0]  in_re_i,
  input  logic signed [DATA_IN_W-1:0]  in_im_i,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic signed [DATA_OUT_W-1:0] out_re_o,
  output logic signed [DATA_OUT_W-1:0] out_im_o,
  output logic [3:0]                   out_idx_o
);

  typedef struct packed {
    logic signed [DATA_IN_W-1:0] re;
    logic signed [DATA_IN_W-1:0] im;
  } data_in_t;

  typedef struct packed {
    logic signed [DATA_OUT_W-1:0] re;
    logic signed [DATA_OUT_W-1:0] im;
  } data_out_t;

  data_in_t             frame   [fft16_pkg::N_POINTS];
  fft16_pkg::mid_cplx_t s1_lane [fft16_pkg::N_POINTS];
  fft16_pkg::mid_cplx_t tw_lane [fft16_pkg::N_POINTS];
  data_out_t            s2_lane [fft16_pkg::N_POINTS];
  logic                 frame_valid;
  logic                 frame_done;
  logic                 tw_valid;

  fft16_loader loader_u (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_re_i      (in_re_i),
    .in_im_i      (in_im_i),
    .in_ready_o   (in_ready_o),
    .frame_done_i (frame_done),
    .frame_valid_o(frame_valid),
    .frame_o      (frame)
  );

  //////////////////////////////////////////////////////////////////////
  // Rank 1, butterfly n2 takes x[n2 + 4r], lane n2*4 + k1 out
  //////////////////////////////////////////////////////////////////////
  for (genvar n2 = 0; n2 < fft16_pkg::RADIX; n2++) begin : stage1_g
    data_in_t             x [fft16_pkg::RADIX];
    fft16_pkg::mid_cplx_t y [fft16_pkg::RADIX];
    logic                 vld;

    for (genvar r = 0; r < fft16_pkg::RADIX; r++) begin : tap_g
      assign x[r] = frame[n2 + 4*r];
      assign s1_lane[n2*4 + r] = y[r];
    end

    r4_butterfly #(.in_t(data_in_t), .out_t(fft16_pkg::mid_cplx_t)) bf_u (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .valid_i(frame_valid),
      .x_i    (x),
      .valid_o(vld),
      .y_o    (y)
    );
  end

  fft16_twiddle twiddle_u (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(stage1_g[0].vld),
    .d_i    (s1_lane),
    .valid_o(tw_valid),
    .d_o    (tw_lane)
  );

  // Rank 2, butterfly k1 gathers lane n2*4 + k1 over n2
  for (genvar k1 = 0; k1 < fft16_pkg::RADIX; k1++) begin : stage2_g
    fft16_pkg::mid_cplx_t x [fft16_pkg::RADIX];
    data_out_t            y [fft16_pkg::RADIX];
    logic                 vld;

    for (genvar r = 0; r < fft16_pkg::RADIX; r++) begin : tap_g
      assign x[r] = tw_lane[r*4 + k1];
      assign s2_lane[k1*4 + r] = y[r];
    end

    r4_butterfly #(.in_t(fft16_pkg::mid_cplx_t), .out_t(data_out_t)) bf_u (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .valid_i(tw_valid),
      .x_i    (x),
      .valid_o(vld),
      .y_o    (y)
    );
  end

  fft16_unloader unloader_u (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (stage2_g[0].vld),
    .frame_i     (s2_lane),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_re_o    (out_re_o),
    .out_im_o    (out_im_o),
    .out_idx_o   (out_idx_o),
    .frame_done_o(frame_done)
  );

endmodule

`default_nettype wire

// File: hw/fft16_twiddle.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_twiddle (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  fft16_pkg::mid_cplx_t  d_i [fft16_pkg::N_POINTS],
  output logic                  valid_o,
  output fft16_pkg::mid_cplx_t  d_o [fft16_pkg::N_POINTS]
);

  localparam int MW   = fft16_pkg::MID_W;
  localparam int PW   = MW + 17;
  localparam int HALF = 1 << (fft16_pkg::TW_FRAC - 1);

  //////////////////////////////////////////////////////////////////////
  // One complex multiplier per lane
  //////////////////////////////////////////////////////////////////////
  for (genvar l = 0; l < fft16_pkg::N_POINTS; l++) begin : lane_g
    // Lane l = n2*4 + k1 takes W16^(n2*k1)
    localparam int M = (l / fft16_pkg::RADIX) * (l % fft16_pkg::RADIX);
    localparam logic signed [15:0] WR = fft16_pkg::TW_RE[M];
    localparam logic signed [15:0] WI = fft16_pkg::TW_IM[M];

    logic signed [MW-1:0] dr;
    logic signed [MW-1:0] di;
    logic signed [PW-1:0] pr;
    logic signed [PW-1:0] pi;
    logic signed [PW-1:0] sr;
    logic signed [PW-1:0] si;

    assign dr = d_i[l].re;
    assign di = d_i[l].im;

    // Round half up, then drop the fraction bits
    assign pr = dr * WR - di * WI + HALF;
    assign pi = dr * WI + di * WR + HALF;
    assign sr = pr >>> fft16_pkg::TW_FRAC;
    assign si = pi >>> fft16_pkg::TW_FRAC;

    always_ff @(posedge clk_i) begin
      d_o[l] <= {sr[MW-1:0], si[MW-1:0]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/fft16_unloader.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_unloader (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                valid_i,
  input  fft16_pkg::out_cplx_t                frame_i [fft16_pkg::N_POINTS],
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic signed [fft16_pkg::OUT_W-1:0]  out_re_o,
  output logic signed [fft16_pkg::OUT_W-1:0]  out_im_o,
  output logic [3:0]                          out_idx_o,
  output logic                                frame_done_o
);

  fft16_pkg::out_cplx_t hold_q [fft16_pkg::N_POINTS];
  logic [3:0]           rd_cnt;
  logic [3:0]           rd_sel;
  logic                 busy;
  logic                 xfer;

  // Bin k sits at butterfly k mod 4, output k div 4
  assign rd_sel = {rd_cnt[1:0], rd_cnt[3:2]};

  assign out_valid_o  = busy;
  assign out_re_o     = hold_q[rd_sel].re;
  assign out_im_o     = hold_q[rd_sel].im;
  assign out_idx_o    = rd_cnt;
  assign xfer         = busy & out_ready_i;
  assign frame_done_o = xfer & (rd_cnt == 4'd15);

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      hold_q <= frame_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read sequencing
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy   <= 1'b0;
      rd_cnt <= '0;
    end else if (valid_i) begin
      busy   <= 1'b1;
      rd_cnt <= '0;
    end else if (xfer) begin
      rd_cnt <= rd_cnt + 4'd1;
      // Last bin leaves, frame slot is free again
      if (rd_cnt == 4'd15) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/r4_butterfly.sv
`timescale 1ns/1ps
`default_nettype none

module r4_butterfly #(
  parameter type in_t  = fft16_pkg::in_cplx_t,
  parameter type out_t = fft16_pkg::mid_cplx_t
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  input  in_t  x_i [fft16_pkg::RADIX],
  output logic valid_o,
  output out_t y_o [fft16_pkg::RADIX]
);

  localparam int IW = $bits(in_t) / 2;
  localparam int OW = $bits(out_t) / 2;

  logic signed [IW-1:0] xr [fft16_pkg::RADIX];
  logic signed [IW-1:0] xi [fft16_pkg::RADIX];
  logic signed [OW-1:0] ar [fft16_pkg::RADIX];
  logic signed [OW-1:0] ai [fft16_pkg::RADIX];

  // Split re/im and sign extend to output width
  always_comb begin
    for (int i = 0; i < fft16_pkg::RADIX; i++) begin
      xr[i] = x_i[i][2*IW-1:IW];
      xi[i] = x_i[i][IW-1:0];
      ar[i] = xr[i];
      ai[i] = xi[i];
    end
  end

  // 4-point DFT, multiplying by +/-j swaps re and im
  always_ff @(posedge clk_i) begin
    y_o[0] <= {ar[0] + ar[1] + ar[2] + ar[3], ai[0] + ai[1] + ai[2] + ai[3]};
    y_o[1] <= {ar[0] + ai[1] - ar[2] - ai[3], ai[0] - ar[1] - ai[2] + ar[3]};
    y_o[2] <= {ar[0] - ar[1] + ar[2] - ar[3], ai[0] - ai[1] + ai[2] - ai[3]};
    y_o[3] <= {ar[0] - ai[1] - ar[2] + ai[3], ai[0] + ar[1] - ai[2] - ar[3]};
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

endmodule

`default_nettype wire

// File: test/fft16_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_asserts (
  input logic                               clk_i,
  input logic                               rst_n_i,
  input logic                               in_valid_i,
  input logic                               in_ready_o,
  input logic signed [fft16_pkg::IN_W-1:0]  in_re_i,
  input logic signed [fft16_pkg::IN_W-1:0]  in_im_i,
  input logic                               out_valid_o,
  input logic                               out_ready_i,
  input logic signed [fft16_pkg::OUT_W-1:0] out_re_o,
  input logic signed [fft16_pkg::OUT_W-1:0] out_im_o,
  input logic [3:0]                         out_idx_o
);

  // Stalled output bin stays put
  out_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=>
      out_valid_o && $stable(out_re_o) && $stable(out_im_o) && $stable(out_idx_o))
    else $error("output stream changed while stalled");

  // Source keeps its sample until accepted
  in_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_re_i) && $stable(in_im_i))
    else $error("input stream changed while stalled");

  reset_idle_a : assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o)
    else $error("out_valid_o high after reset");

endmodule

bind fft16_top fft16_asserts asserts_u (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .in_valid_i (in_valid_i),
  .in_ready_o (in_ready_o),
  .in_re_i    (in_re_i),
  .in_im_i    (in_im_i),
  .out_valid_o(out_valid_o),
  .out_ready_i(out_ready_i),
  .out_re_o   (out_re_o),
  .out_im_o   (out_im_o),
  .out_idx_o  (out_idx_o)
);

`default_nettype wire

// File: test/fft16_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_tb;

  // Budget of 40 cycles per frame for up to 16 frames
  localparam int     MAX_CYCLES = 16 * 40 + 100;
  localparam longint HALF       = longint'(1) << (fft16_pkg::TW_FRAC - 1);

  logic                                  clk_i = 1'b0;
  logic                                  rst_n_i;
  logic                                  in_valid_i;
  logic                                  in_ready_o;
  logic signed [fft16_pkg::IN_W-1:0]     in_re_i;
  logic signed [fft16_pkg::IN_W-1:0]     in_im_i;
  logic                                  out_valid_o;
  logic                                  out_ready_i;
  logic signed [fft16_pkg::OUT_W-1:0]    out_re_o;
  logic signed [fft16_pkg::OUT_W-1:0]    out_im_o;
  logic [3:0]                            out_idx_o;

  int                   src_re [$];
  int                   src_im [$];
  fft16_pkg::out_cplx_t exp_q  [$];
  int                   frm_re [fft16_pkg::N_POINTS];
  int                   frm_im [fft16_pkg::N_POINTS];
  logic [31:0]          lfsr_q;
  bit                   saw_in_stall;
  int                   cycle_cnt = 0;

  fft16_top #(
    .DATA_IN_W (fft16_pkg::IN_W),
    .DATA_OUT_W(fft16_pkg::OUT_W)
  ) dut0 (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_re_i    (in_re_i),
    .in_im_i    (in_im_i),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_re_o   (out_re_o),
    .out_im_o   (out_im_o),
    .out_idx_o  (out_idx_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      abort_run("timeout, the DUT stopped producing output");
    end
  end

  task automatic abort_run(input string why);
    $display("TB FAILED");
    $fatal(1, "%s", why);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_out(input string name, input fft16_pkg::out_cplx_t exp,
                           input fft16_pkg::out_cplx_t act, input int bin_no);
    if (act !== exp) begin
      $display("CHECK FAILED %s bin %0d: expected (%0d, %0d) actual (%0d, %0d)",
               name, bin_no, exp.re, exp.im, act.re, act.im);
      abort_run("bin value mismatch");
    end
  endtask

  task automatic check_idx(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s index: expected %0d actual %0d", name, exp, act);
      abort_run("bin index mismatch");
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b actual %b", name, exp, act);
      abort_run("control flag mismatch");
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_take(input int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < nbits; b++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic longint wrap(input longint v, input int w);
    longint m;
    m = longint'(1) << w;
    v = v & (m - 1);
    if (v >= (m >> 1)) begin
      v = v - m;
    end
    return v;
  endfunction

  // Multiply by (-j)^q
  function automatic void rotate(input int q, inout longint re, inout longint im);
    longint t;
    t = re;
    case (q % 4)
      1: begin
        re = im;
        im = -t;
      end
      2: begin
        re = -re;
        im = -im;
      end
      3: begin
        re = -im;
        im = t;
      end
      default: ;
    endcase
  endfunction

  function automatic void run_model();
    longint               ar;
    longint               ai;
    longint               sr;
    longint               si;
    longint               twr [fft16_pkg::N_POINTS];
    longint               twi [fft16_pkg::N_POINTS];
    fft16_pkg::out_cplx_t res [fft16_pkg::N_POINTS];
    int                   m;
    // Rank 1 and twiddles per lane n2*4 + k1
    for (int n2 = 0; n2 < 4; n2++) begin
      for (int k1 = 0; k1 < 4; k1++) begin
        sr = 0;
        si = 0;
        for (int r = 0; r < 4; r++) begin
          ar = frm_re[n2 + 4*r];
          ai = frm_im[n2 + 4*r];
          rotate(r * k1, ar, ai);
          sr += ar;
          si += ai;
        end
        m = n2 * k1;
        twr[n2*4 + k1] = wrap((sr * fft16_pkg::TW_RE[m] - si * fft16_pkg::TW_IM[m] + HALF)
                              >>> fft16_pkg::TW_FRAC, fft16_pkg::MID_W);
        twi[n2*4 + k1] = wrap((sr * fft16_pkg::TW_IM[m] + si * fft16_pkg::TW_RE[m] + HALF)
                              >>> fft16_pkg::TW_FRAC, fft16_pkg::MID_W);
      end
    end
    // Rank 2 gives X[k1 + 4*k2]
    for (int k1 = 0; k1 < 4; k1++) begin
      for (int k2 = 0; k2 < 4; k2++) begin
        sr = 0;
        si = 0;
        for (int n2 = 0; n2 < 4; n2++) begin
          ar = twr[n2*4 + k1];
          ai = twi[n2*4 + k1];
          rotate(n2 * k2, ar, ai);
          sr += ar;
          si += ai;
        end
        res[k1 + 4*k2].re = wrap(sr, fft16_pkg::OUT_W);
        res[k1 + 4*k2].im = wrap(si, fft16_pkg::OUT_W);
      end
    end
    for (int k = 0; k < fft16_pkg::N_POINTS; k++) begin
      exp_q.push_back(res[k]);
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stream drivers
  //////////////////////////////////////////////////////////////////////
  function automatic void queue_frame(input bit with_model);
    for (int n = 0; n < fft16_pkg::N_POINTS; n++) begin
      src_re.push_back(frm_re[n]);
      src_im.push_back(frm_im[n]);
    end
    if (with_model) begin
      run_model();
    end
  endfunction

  function automatic void fill_random();
    logic [31:0]       v;
    logic signed [15:0] s;
    for (int n = 0; n < fft16_pkg::N_POINTS; n++) begin
      v         = lfsr_take(16);
      s         = v[15:0];
      frm_re[n] = s;
      v         = lfsr_take(16);
      s         = v[15:0];
      frm_im[n] = s;
    end
  endfunction

  task automatic send_all();
    int re;
    int im;
    bit taken;
    while (src_re.size() > 0) begin
      re = src_re.pop_front();
      im = src_im.pop_front();
      in_valid_i <= 1'b1;
      in_re_i    <= re[15:0];
      in_im_i    <= im[15:0];
      do begin
        @(negedge clk_i);
        taken = in_ready_o;
        @(posedge clk_i);
      end while (!taken);
    end
    in_valid_i <= 1'b0;
  endtask

  task automatic recv_all(input string name, input int nbins, input bit stall);
    fft16_pkg::out_cplx_t act;
    logic [31:0]          r;
    int                   k;
    k = 0;
    while (k < nbins) begin
      if (stall) begin
        r = lfsr_take(1);
        out_ready_i <= r[0];
      end else begin
        out_ready_i <= 1'b1;
      end
      @(negedge clk_i);
      // Input side blocked while a stalled frame sits in the unloader
      if (!in_ready_o && out_valid_o && !out_ready_i) begin
        saw_in_stall = 1'b1;
      end
      if (out_valid_o && out_ready_i) begin
        act.re = out_re_o;
        act.im = out_im_o;
        check_idx(name, 4'(k % 16), out_idx_o);
        check_out(name, exp_q.pop_front(), act, k % 16);
        k++;
      end
      @(posedge clk_i);
    end
    out_ready_i <= 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic reset_state();
    @(negedge clk_i);
    compare_flag("reset out_valid", 1'b0, out_valid_o);
    compare_flag("reset in_ready", 1'b1, in_ready_o);
    @(posedge clk_i);
  endtask

  task automatic impulse_frame();
    fft16_pkg::out_cplx_t e;
    for (int n = 0; n < fft16_pkg::N_POINTS; n++) begin
      frm_re[n] = 0;
      frm_im[n] = 0;
    end
    frm_re[0] = 1234;
    frm_im[0] = -567;
    queue_frame(1'b0);
    // Flat spectrum equal to x[0]
    e.re = 1234;
    e.im = -567;
    for (int k = 0; k < fft16_pkg::N_POINTS; k++) begin
      exp_q.push_back(e);
    end
    fork
      send_all();
      recv_all("impulse", 16, 1'b0);
    join
  endtask

  task automatic constant_frame();
    fft16_pkg::out_cplx_t e;
    for (int n = 0; n < fft16_pkg::N_POINTS; n++) begin
      frm_re[n] = 1000;
      frm_im[n] = 0;
    end
    queue_frame(1'b0);
    e.re = 16 * 1000;
    e.im = 0;
    exp_q.push_back(e);
    e.re = 0;
    for (int k = 1; k < fft16_pkg::N_POINTS; k++) begin
      exp_q.push_back(e);
    end
    fork
      send_all();
      recv_all("constant", 16, 1'b0);
    join
  endtask

  task automatic random_frames(input string name, input bit stall);
    for (int f = 0; f < 4; f++) begin
      fill_random();
      queue_frame(1'b1);
    end
    fork
      send_all();
      recv_all(name, 64, stall);
    join
  endtask

  initial begin
    lfsr_q       = 32'hb0abc24c;
    saw_in_stall = 1'b0;
    rst_n_i     <= 1'b0;
    in_valid_i  <= 1'b0;
    in_re_i     <= '0;
    in_im_i     <= '0;
    out_ready_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    reset_state();
    impulse_frame();
    constant_frame();
    random_frames("random", 1'b0);
    saw_in_stall = 1'b0;
    random_frames("backpressure", 1'b1);
    compare_flag("backpressure in_ready low", 1'b1, saw_in_stall);

    @(posedge clk_i);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
